//--- hdl/platform_pkg.sv
`default_nettype none

package platform_pkg;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int STRB_W   = DATA_W / 8;
    localparam int MTIME_W  = 64;
    localparam int IRQ_ID_W = 5;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [STRB_W-1:0]   strb_t;
    typedef logic [MTIME_W-1:0]  mtime_t;
    typedef logic [IRQ_ID_W-1:0] irq_id_t;     // 0 = no interrupt

    // top address nibble map
    localparam logic [3:0] RAM_LIMIT_NIBBLE = 4'h2;  // 0..1
    localparam logic [3:0] TIMER_NIBBLE     = 4'h2;
    localparam logic [3:0] IRQ_LIMIT_NIBBLE = 4'h8;  // 3..7

    typedef enum logic [1:0] {
        TARGET_RAM,
        TARGET_TIMER,
        TARGET_IRQ,
        TARGET_NONE
    } bus_target_e;

    typedef struct packed {
        addr_t paddr;
        logic  pwrite;
        data_t pwdata;
        strb_t pstrb;
    } apb_req_t;

    typedef struct packed {
        addr_t word_idx;   // already reduced modulo the RAM size
        logic  we;
        data_t wdata;
        strb_t strb;
    } ram_req_t;

    // byte lanes of new_word replace old_word where strb is set
    function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
        data_t merged;
        merged = old_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

//--- hdl/bus_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module bus_decoder
    import platform_pkg::*;
(
    input  logic     clk,
    input  logic     rst_i,
    // APB completer
    input  logic     psel_i,
    input  logic     penable_i,
    input  apb_req_t apb_req_i,
    output logic     pready_o,
    output data_t    prdata_o,
    output logic     pslverr_o,
    // peripherals
    output apb_req_t periph_req_o,
    output logic     timer_acc_o,
    output logic     irq_acc_o,
    input  data_t    timer_rdata_i,
    input  data_t    irq_rdata_i,
    // RAM through the arbiter
    output logic     ram_req_o,
    input  logic     ram_valid_i,
    input  data_t    ram_rdata_i
);

    bus_target_e target_d, target_q;
    logic [3:0]  nibble;
    logic        setup, access;

    assign nibble = apb_req_i.paddr[31:28];
    assign setup  = psel_i && !penable_i;
    assign access = psel_i && penable_i;

    //////////////////////////////
    // setup phase
    //////////////////////////////

    always_comb begin
        if (nibble < RAM_LIMIT_NIBBLE) begin
            target_d = TARGET_RAM;
        end else if (nibble == TIMER_NIBBLE) begin
            target_d = TARGET_TIMER;
        end else if (nibble < IRQ_LIMIT_NIBBLE) begin
            target_d = TARGET_IRQ;
        end else begin
            target_d = TARGET_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            target_q <= TARGET_NONE;
        end else if (setup) begin
            target_q <= target_d;
        end
    end

    assign periph_req_o = apb_req_i;
    assign timer_acc_o  = setup && (target_d == TARGET_TIMER);   // one cycle only
    assign irq_acc_o    = setup && (target_d == TARGET_IRQ);

    // held from setup until the arbiter answers
    assign ram_req_o = setup ? (target_d == TARGET_RAM) : (access && target_q == TARGET_RAM);

    //////////////////////////////
    // access phase
    //////////////////////////////

    always_comb begin
        case (target_q)
            TARGET_RAM:   prdata_o = ram_rdata_i;
            TARGET_TIMER: prdata_o = timer_rdata_i;
            TARGET_IRQ:   prdata_o = irq_rdata_i;
            default:      prdata_o = '0;
        endcase
    end

    assign pready_o  = access && (target_q != TARGET_RAM || ram_valid_i);
    assign pslverr_o = pready_o && (target_q == TARGET_NONE);

    // completion only in an access phase that followed a setup
    assert property (@(posedge clk) disable iff (rst_i)
        pready_o |-> penable_i && $past(psel_i));

endmodule

`default_nettype wire

//--- hdl/ram_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module ram_arbiter
    import platform_pkg::*;
#(
    parameter int RAM_WORDS = 1024
)
(
    input  logic     clk,
    input  logic     rst_i,
    input  logic     fetch_req_i,
    input  addr_t    fetch_addr_i,
    output logic     fetch_valid_o,
    input  logic     data_req_i,
    input  apb_req_t data_i,
    output logic     data_valid_o,
    output data_t    rdata_o,
    output ram_req_t ram_req_o,
    input  data_t    ram_rdata_i
);

    logic  fetch_elig, data_elig;
    logic  grant_fetch, grant_data;
    logic  fetch_out_q, data_out_q;    // granted last cycle, data on its way
    logic  last_fetch_q;               // fetch was served most recently
    addr_t sel_addr;

    // a port with a read in flight waits for its valid
    assign fetch_elig  = fetch_req_i && !fetch_out_q;
    assign data_elig   = data_req_i && !data_out_q;
    assign grant_fetch = fetch_elig && (!data_elig || !last_fetch_q);
    assign grant_data  = data_elig && !grant_fetch;

    assign sel_addr = grant_fetch ? fetch_addr_i : data_i.paddr;

    always_comb begin
        ram_req_o.word_idx = addr_t'((sel_addr >> 2) % addr_t'(RAM_WORDS));
        ram_req_o.we       = grant_data && data_i.pwrite;   // fetch never writes
        ram_req_o.wdata    = data_i.pwdata;
        ram_req_o.strb     = data_i.pstrb;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            fetch_out_q  <= 1'b0;
            data_out_q   <= 1'b0;
            last_fetch_q <= 1'b0;
        end else begin
            fetch_out_q <= grant_fetch;
            data_out_q  <= grant_data;
            if (grant_fetch || grant_data) begin
                last_fetch_q <= grant_fetch;
            end
        end
    end

    assign fetch_valid_o = fetch_out_q;
    assign data_valid_o  = data_out_q;
    assign rdata_o       = ram_rdata_i;   // one RAM, valid says whose it is

    assert property (@(posedge clk) disable iff (rst_i) !(fetch_valid_o && data_valid_o));
    assert property (@(posedge clk) disable iff (rst_i)
        fetch_elig |-> ##[1:2] fetch_valid_o);
    assert property (@(posedge clk) disable iff (rst_i)
        data_elig |-> ##[1:2] data_valid_o);

endmodule

`default_nettype wire

//--- hdl/platform_ram.sv
`timescale 1ns/10ps
`default_nettype none

module platform_ram
    import platform_pkg::*;
#(
    parameter int RAM_WORDS = 1024
)
(
    input  logic     clk,
    input  ram_req_t ram_req_i,
    output data_t    rdata_o
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    data_t            mem [RAM_WORDS];
    logic [IDX_W-1:0] idx;

    // word index arrives already in range
    assign idx = ram_req_i.word_idx[IDX_W-1:0];

    //////////////////////////////
    // single port, read first
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (ram_req_i.we) begin
            mem[idx] <= merge_bytes(mem[idx], ram_req_i.wdata, ram_req_i.strb);
        end
        rdata_o <= mem[idx];   // old word on a write cycle
    end

endmodule

`default_nettype wire

//--- hdl/machine_timer.sv
`timescale 1ns/10ps
`default_nettype none

module machine_timer
    import platform_pkg::*;
(
    input  logic     clk,
    input  logic     rst_i,
    input  logic     acc_i,
    input  apb_req_t req_i,
    output data_t    rdata_o,
    output logic     mti_o,
    output mtime_t   mtime_o
);

    mtime_t     mtime_q;
    mtime_t     mtimecmp_q;
    logic [1:0] reg_sel;
    logic       wr_cmp_lo, wr_cmp_hi;

    assign reg_sel   = req_i.paddr[3:2];
    assign wr_cmp_lo = acc_i && req_i.pwrite && (reg_sel == 2'd2);
    assign wr_cmp_hi = acc_i && req_i.pwrite && (reg_sel == 2'd3);

    // free running, writes to mtime are dropped
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mtimecmp_q <= '1;   // no interrupt until programmed
        end else begin
            if (wr_cmp_lo) begin
                mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], req_i.pwdata, req_i.pstrb);
            end
            if (wr_cmp_hi) begin
                mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], req_i.pwdata, req_i.pstrb);
            end
        end
    end

    // read register, sampled in setup
    always_ff @(posedge clk) begin
        if (acc_i) begin
            case (reg_sel)
                2'd0:    rdata_o <= mtime_q[31:0];
                2'd1:    rdata_o <= mtime_q[63:32];
                2'd2:    rdata_o <= mtimecmp_q[31:0];
                default: rdata_o <= mtimecmp_q[63:32];
            endcase
        end
    end

    assign mti_o   = (mtime_q >= mtimecmp_q);
    assign mtime_o = mtime_q;

endmodule

`default_nettype wire

//--- hdl/irq_controller.sv
`timescale 1ns/10ps
`default_nettype none

module irq_controller
    import platform_pkg::*;
#(
    parameter int IRQ_COUNT = 8   // at most 31
)
(
    input  logic               clk,
    input  logic               rst_i,
    input  logic               acc_i,
    input  apb_req_t           req_i,
    output data_t              rdata_o,
    input  logic [IRQ_COUNT:1] irq_src_i,
    output logic               mei_o
);

    logic [IRQ_COUNT:1] enable_q;
    logic [IRQ_COUNT:1] in_service_q;
    logic [IRQ_COUNT:1] pending;
    logic [1:0]         reg_sel;
    logic               wr_enable, claim_rd, complete_wr;
    irq_id_t            claim_id;
    irq_id_t            cpl_id;

    assign reg_sel     = req_i.paddr[3:2];
    assign wr_enable   = acc_i && req_i.pwrite && (reg_sel == 2'd0);
    assign claim_rd    = acc_i && !req_i.pwrite && (reg_sel == 2'd2);
    assign complete_wr = acc_i && req_i.pwrite && (reg_sel == 2'd2);
    assign cpl_id      = req_i.pwdata[IRQ_ID_W-1:0];

    // level sources, masked, minus the ones being serviced
    assign pending = irq_src_i & enable_q & ~in_service_q;
    assign mei_o   = |pending;

    // lowest pending id wins
    always_comb begin
        claim_id = '0;
        for (int i = IRQ_COUNT; i >= 1; i--) begin
            if (pending[i]) begin
                claim_id = irq_id_t'(i);
            end
        end
    end

    //////////////////////////////
    // enable and in-service
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            enable_q     <= '0;
            in_service_q <= '0;
        end else begin
            if (wr_enable) begin
                enable_q <= req_i.pwdata[IRQ_COUNT:1];   // bit n enables source n
            end
            for (int i = 1; i <= IRQ_COUNT; i++) begin
                if (claim_rd && claim_id == irq_id_t'(i)) begin
                    in_service_q[i] <= 1'b1;
                end else if (complete_wr && cpl_id == irq_id_t'(i)) begin
                    in_service_q[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_i) begin
            case (reg_sel)
                2'd0:    rdata_o <= data_t'({enable_q, 1'b0});
                2'd1:    rdata_o <= data_t'({pending, 1'b0});
                2'd2:    rdata_o <= data_t'(claim_id);   // 0 when nothing pending
                default: rdata_o <= '0;
            endcase
        end
    end

    // a newly set in-service bit was pending the cycle before
    assert property (@(posedge clk) disable iff (rst_i)
        (in_service_q & ~$past(in_service_q) & ~$past(pending)) == '0);

endmodule

`default_nettype wire

//--- hdl/platform_top.sv
`timescale 1ns/10ps
`default_nettype none

module platform_top
    import platform_pkg::*;
#(
    parameter int RAM_WORDS = 1024,
    parameter int IRQ_COUNT = 8
)
(
    input  logic               clk,
    input  logic               rst_i,
    // APB data port
    input  logic               psel_i,
    input  logic               penable_i,
    input  apb_req_t           apb_req_i,
    output logic               pready_o,
    output data_t              prdata_o,
    output logic               pslverr_o,
    // instruction fetch
    input  logic               fetch_req_i,
    input  addr_t              fetch_addr_i,
    output logic               fetch_valid_o,
    output data_t              fetch_data_o,
    // interrupts and time
    input  logic [IRQ_COUNT:1] irq_src_i,
    output logic               mti_o,
    output logic               mei_o,
    output mtime_t             mtime_o
);

    apb_req_t periph_req;
    logic     timer_acc, irq_acc;
    data_t    timer_rdata, irq_rdata;
    logic     ram_data_req, ram_data_valid;
    data_t    ram_rdata;      // arbiter read data, shared by both ports
    ram_req_t ram_req;
    data_t    ram_dout;

    //////////////////////////////
    // data bus
    //////////////////////////////

    bus_decoder u_decoder (
        .clk           (clk),
        .rst_i         (rst_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .apb_req_i     (apb_req_i),
        .pready_o      (pready_o),
        .prdata_o      (prdata_o),
        .pslverr_o     (pslverr_o),
        .periph_req_o  (periph_req),
        .timer_acc_o   (timer_acc),
        .irq_acc_o     (irq_acc),
        .timer_rdata_i (timer_rdata),
        .irq_rdata_i   (irq_rdata),
        .ram_req_o     (ram_data_req),
        .ram_valid_i   (ram_data_valid),
        .ram_rdata_i   (ram_rdata)
    );

    //////////////////////////////
    // shared RAM
    //////////////////////////////

    ram_arbiter #(.RAM_WORDS(RAM_WORDS)) u_arbiter (
        .clk           (clk),
        .rst_i         (rst_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_valid_o (fetch_valid_o),
        .data_req_i    (ram_data_req),
        .data_i        (periph_req),
        .data_valid_o  (ram_data_valid),
        .rdata_o       (ram_rdata),
        .ram_req_o     (ram_req),
        .ram_rdata_i   (ram_dout)
    );

    platform_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .clk       (clk),
        .ram_req_i (ram_req),
        .rdata_o   (ram_dout)
    );

    assign fetch_data_o = ram_rdata;

    //////////////////////////////
    // timer and interrupts
    //////////////////////////////

    machine_timer u_timer (
        .clk     (clk),
        .rst_i   (rst_i),
        .acc_i   (timer_acc),
        .req_i   (periph_req),
        .rdata_o (timer_rdata),
        .mti_o   (mti_o),
        .mtime_o (mtime_o)
    );

    irq_controller #(.IRQ_COUNT(IRQ_COUNT)) u_irq (
        .clk       (clk),
        .rst_i     (rst_i),
        .acc_i     (irq_acc),
        .req_i     (periph_req),
        .rdata_o   (irq_rdata),
        .irq_src_i (irq_src_i),
        .mei_o     (mei_o)
    );

endmodule

`default_nettype wire

//--- bench/platform_checker.sv
`timescale 1ns/10ps
`default_nettype none

module platform_checker
    import platform_pkg::*;
#(
    parameter int RAM_WORDS = 1024,
    parameter int NAME_W    = 8 * 24
)
(
    input  logic              clk,
    input  logic              rst_i,
    // DUT ports being watched
    input  logic              psel_i,
    input  logic              penable_i,
    input  apb_req_t          apb_req_i,
    input  logic              pready_i,
    input  data_t             prdata_i,
    input  logic              pslverr_i,
    input  addr_t             fetch_addr_i,
    input  logic              fetch_valid_i,
    input  data_t             fetch_data_i,
    input  logic              mti_i,
    input  logic              mei_i,
    input  mtime_t            mtime_i,
    // current trace step
    input  logic [NAME_W-1:0] name_i,
    input  logic [15:0]       kind_i,
    input  data_t             expect_i,
    input  logic              probe_i,    // sample an interrupt line this cycle
    output int                checks_o,
    output int                errors_o
);

    data_t  model [int unsigned];   // RAM words written so far
    int     checks = 0;
    int     errors = 0;
    data_t  last_inc;
    logic   have_last = 1'b0;
    mtime_t mtime_exp = '0;         // cycles counted since reset

    assign checks_o = checks;
    assign errors_o = errors;

    function automatic string vec_to_name(logic [NAME_W-1:0] v);
        string s;
        s = "";
        for (int i = NAME_W / 8 - 1; i >= 0; i--) begin
            if (v[8*i +: 8] != 8'h00) begin
                s = $sformatf("%s%c", s, v[8*i +: 8]);
            end
        end
        return s;
    endfunction

    function automatic int unsigned word_key(addr_t a);
        return (a >> 2) % RAM_WORDS;
    endfunction

    function automatic data_t model_word(addr_t a);
        if (model.exists(word_key(a))) begin
            return model[word_key(a)];
        end
        return 'x;   // never written
    endfunction

    // strobe bits widened to a byte mask
    function automatic data_t apply_strobes(data_t old_word, data_t new_word, strb_t strb);
        data_t mask;
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = {8{strb[b]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic compare(input string test, input data_t exp, input data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", test, exp, act);
        end else begin
            $display("ok   %s", test);
        end
    endtask

    task automatic compare_time(input string test, input mtime_t exp, input mtime_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", test, exp, act);
        end else begin
            $display("ok   %s", test);
        end
    endtask

    // the first read only sets the reference
    task automatic check_increase(input string test, input data_t act);
        if (have_last) begin
            checks++;
            if (act <= last_inc) begin
                errors++;
                $display("Fail %s: expected above %h, actual %h", test, last_inc, act);
            end else begin
                $display("ok   %s", test);
            end
        end
        last_inc  = act;
        have_last = 1'b1;
    endtask

    //////////////////////////////
    // sampling on the rising edge
    //////////////////////////////

    always @(posedge clk) begin : watch
        string test;
        data_t old_word;
        test = vec_to_name(name_i);
        if (rst_i) begin
            mtime_exp = '0;
        end else begin
            if (psel_i && penable_i && pready_i) begin
                if (apb_req_i.pwrite) begin
                    if (apb_req_i.paddr[31:28] < 4'h2) begin   // RAM region
                        old_word = model_word(apb_req_i.paddr);
                        model[word_key(apb_req_i.paddr)] =
                            apply_strobes(old_word, apb_req_i.pwdata, apb_req_i.pstrb);
                    end
                    compare({test, " pslverr"}, 32'd0, {31'b0, pslverr_i});
                end else begin
                    case (kind_i)
                        "RM", "CF": compare(test, model_word(apb_req_i.paddr), prdata_i);
                        "RI": begin
                            compare_time({test, " mtime"}, mtime_exp, mtime_i);
                            check_increase(test, prdata_i);
                        end
                        "ER":       compare({test, " pslverr"}, 32'd1, {31'b0, pslverr_i});
                        default:    compare(test, expect_i, prdata_i);
                    endcase
                end
            end
            if (fetch_valid_i) begin
                compare({test, " fetch"}, model_word(fetch_addr_i), fetch_data_i);
            end
            if (probe_i) begin
                compare(test, expect_i, {31'b0, (kind_i == "SM") ? mti_i : mei_i});
            end
            mtime_exp = mtime_exp + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- bench/platform_tb.sv
`timescale 1ns/10ps
`default_nettype none

module platform_tb
    import platform_pkg::*;
();

    localparam int RAM_WORDS = 1024;
    localparam int IRQ_COUNT = 8;
    localparam int TIMEOUT   = 100;     // cycles per wait
    localparam int NAME_W    = 8 * 24;

    logic               clk;
    logic               rst;
    logic               psel, penable;
    apb_req_t           apb_req;
    logic               pready, pslverr;
    data_t              prdata;
    logic               fetch_req, fetch_valid;
    addr_t              fetch_addr;
    data_t              fetch_data;
    logic [IRQ_COUNT:1] irq_src;
    logic               mti, mei;
    mtime_t             mtime;

    logic [NAME_W-1:0]  name_vec;
    logic [15:0]        kind_vec;
    data_t              exp_val;
    logic               probe;
    int                 checks_seen, errors_seen;
    logic               aborted;
    int                 seed;
    addr_t              ram_addrs [$];   // written RAM words, fetch targets
    data_t              last_rd;

    platform_top #(.RAM_WORDS(RAM_WORDS), .IRQ_COUNT(IRQ_COUNT)) dut (
        .clk           (clk),
        .rst_i         (rst),
        .psel_i        (psel),
        .penable_i     (penable),
        .apb_req_i     (apb_req),
        .pready_o      (pready),
        .prdata_o      (prdata),
        .pslverr_o     (pslverr),
        .fetch_req_i   (fetch_req),
        .fetch_addr_i  (fetch_addr),
        .fetch_valid_o (fetch_valid),
        .fetch_data_o  (fetch_data),
        .irq_src_i     (irq_src),
        .mti_o         (mti),
        .mei_o         (mei),
        .mtime_o       (mtime)
    );

    platform_checker #(.RAM_WORDS(RAM_WORDS), .NAME_W(NAME_W)) u_checker (
        .clk           (clk),
        .rst_i         (rst),
        .psel_i        (psel),
        .penable_i     (penable),
        .apb_req_i     (apb_req),
        .pready_i      (pready),
        .prdata_i      (prdata),
        .pslverr_i     (pslverr),
        .fetch_addr_i  (fetch_addr),
        .fetch_valid_i (fetch_valid),
        .fetch_data_i  (fetch_data),
        .mti_i         (mti),
        .mei_i         (mei),
        .mtime_i       (mtime),
        .name_i        (name_vec),
        .kind_i        (kind_vec),
        .expect_i      (exp_val),
        .probe_i       (probe),
        .checks_o      (checks_seen),
        .errors_o      (errors_seen)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // drivers
    //////////////////////////////

    task automatic set_test(input string name, input string kind, input data_t expv);
        int len;
        len = (name.len() < NAME_W / 8) ? name.len() : NAME_W / 8;
        name_vec = '0;
        for (int i = 0; i < len; i++) begin
            name_vec[8*(len-1-i) +: 8] = name.getc(i);
        end
        kind_vec = {kind.getc(0), kind.getc(1)};
        exp_val  = expv;
    endtask

    // starts and ends on a falling edge
    task automatic apb_transfer(input string name, input addr_t addr, input logic wr,
                                input data_t wdata, input strb_t strb, output data_t rd);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        rd     = '0;
        psel           = 1'b1;
        penable        = 1'b0;
        apb_req.paddr  = addr;
        apb_req.pwrite = wr;
        apb_req.pwdata = wdata;
        apb_req.pstrb  = strb;
        @(negedge clk);
        penable = 1'b1;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            done = pready;
            rd   = prdata;
        end
        if (!done) begin
            $display("Test %s hung, no pready within %0d cycles.", name, TIMEOUT);
            aborted = 1'b1;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic fetch_word(input string name, input addr_t addr);
        int   cycles;
        logic done;
        cycles     = 0;
        done       = 1'b0;
        fetch_req  = 1'b1;
        fetch_addr = addr;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            done = fetch_valid;
        end
        if (!done) begin
            $display("Test %s hung, no fetch_valid within %0d cycles.", name, TIMEOUT);
            aborted = 1'b1;
        end
        @(negedge clk);
        fetch_req = 1'b0;
    endtask

    task automatic run_step(input string name, input string kind, input addr_t addr,
                            input data_t wdata, input strb_t strb, input data_t expv);
        data_t rd;
        int    pick;
        set_test(name, kind, expv);
        case (kind_vec)
            "WR": begin
                apb_transfer(name, addr, 1'b1, wdata, strb, rd);
                if (addr[31:28] < 4'h2) begin
                    ram_addrs.push_back(addr);
                end
            end
            "WL": apb_transfer(name, addr, 1'b1, last_rd, strb, rd);
            "RD", "RM", "ER": apb_transfer(name, addr, 1'b0, '0, '0, rd);
            "RI": begin
                apb_transfer(name, addr, 1'b0, '0, '0, rd);
                last_rd = rd;   // mtimecmp source for WL
            end
            "CF": begin
                pick = 0;
                if (ram_addrs.size() > 0) begin
                    pick = $unsigned($random(seed)) % ram_addrs.size();
                end
                fork
                    apb_transfer(name, addr, 1'b0, '0, '0, rd);
                    fetch_word(name, ram_addrs[pick]);
                join
            end
            "IS": begin
                irq_src = wdata[IRQ_COUNT:1];   // bit n drives source n
                @(negedge clk);
            end
            "SM", "SE": begin
                probe = 1'b1;
                @(negedge clk);
                probe = 1'b0;
            end
            default: begin
                $display("Trace step %s has an unknown operation %s.", name, kind);
                aborted = 1'b1;
            end
        endcase
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int    fd;
        int    n;
        string line, name, kind;
        addr_t addr;
        data_t wdata, expv;
        strb_t strb;
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        apb_req    = '0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        irq_src    = '0;
        name_vec   = '0;
        kind_vec   = '0;
        exp_val    = '0;
        probe      = 1'b0;
        aborted    = 1'b0;
        last_rd    = '0;
        seed       = 32'h066f_da8d;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("bench/platform_trace.txt", "r");
        if (fd == 0) begin
            $display("The trace file bench/platform_trace.txt could not be opened.");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %s %h %h %h %h", name, kind, addr, wdata, strb, expv);
            if (n == 6) begin
                run_step(name, kind, addr, wdata, strb, expv);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        @(negedge clk);
        $display("%0d checks, %0d failed", checks_seen, errors_seen);
        if (errors_seen == 0 && !aborted) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hdl/platform_pkg.sv
hdl/bus_decoder.sv
hdl/ram_arbiter.sv
hdl/platform_ram.sv
hdl/machine_timer.sv
hdl/irq_controller.sv
hdl/platform_top.sv
bench/platform_checker.sv
bench/platform_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the platform testbench with Verilator, run it, and judge the output
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module platform_tb -f sources.f -o platform_sim

out=$(./obj_dir/platform_sim)
echo "$out"

if echo "$out" | grep -q "Finished with no errors"; then
    exit 0
fi
exit 1

//--- bench/platform_trace.txt
# name kind addr data strb expect, numbers in hex, expect is 0 where the RAM model decides
# WR/WL write, RD/RI/RM/ER read, CF read with a fetch, IS drives sources, SM/SE check mti/mei
ram_wr0     WR 00000000 11223344 f 00000000
ram_wr1     WR 00000004 a5a5a5a5 f 00000000
ram_wr2     WR 00000008 deadbeef f 00000000
ram_wr3     WR 0000000c 01234567 f 00000000
ram_wr4     WR 00000ffc cafef00d f 00000000
ram_part1   WR 00000004 0000ff00 2 00000000
ram_part2   WR 00000008 77000077 9 00000000
ram_rd0     RM 00000000 00000000 0 00000000
ram_rd1     RM 00000004 00000000 0 00000000
ram_rd2     RM 00000008 00000000 0 00000000
ram_rd3     RM 0000000c 00000000 0 00000000
ram_rd4     RM 00000ffc 00000000 0 00000000
ram_cont0   CF 00000000 00000000 0 00000000
ram_cont1   CF 0000000c 00000000 0 00000000
ram_cont2   CF 00000004 00000000 0 00000000
ram_cont3   CF 00000ffc 00000000 0 00000000
mtime_rd0   RI 20000000 00000000 0 00000000
mtime_rd1   RI 20000000 00000000 0 00000000
cmp_hi_zero WR 2000000c 00000000 f 00000000
mti_low     SM 00000000 00000000 0 00000000
cmp_lo_now  WL 20000008 00000000 f 00000000
mti_high    SM 00000000 00000000 0 00000001
cmp_lo_max  WR 20000008 ffffffff f 00000000
cmp_hi_max  WR 2000000c ffffffff f 00000000
mti_clear   SM 00000000 00000000 0 00000000
irq_enable  WR 30000000 00000024 f 00000000
irq_raise   IS 00000000 00000024 0 00000000
mei_high    SE 00000000 00000000 0 00000001
claim_2     RD 30000008 00000000 0 00000002
claim_5     RD 30000008 00000000 0 00000005
mei_low     SE 00000000 00000000 0 00000000
complete_2  WR 30000008 00000002 f 00000000
mei_again   SE 00000000 00000000 0 00000001
irq_raise3  IS 00000000 0000002c 0 00000000
pending_rd  RD 30000004 00000000 0 00000004
unmapped    ER 90000000 00000000 0 00000000
